// File: logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] u32_t;

    localparam int TLB_ENTRY_NUM = 4;

    typedef logic [1:0] plv_t;

    // Bit 0 set selects a cached access
    typedef logic [1:0] mat_t;

    typedef enum logic [1:0] {
        BT_BYTE = 2'd0,
        BT_HALF = 2'd1,
        BT_WORD = 2'd2
    } byte_type_e;

    typedef enum logic {
        LOOKUP_LOAD  = 1'b0,
        LOOKUP_STORE = 1'b1
    } lookup_e;

    // Encodings follow the architectural ECODE field
    typedef enum logic [5:0] {
        EC_NONE = 6'h00,
        EC_PIL  = 6'h01,
        EC_PIS  = 6'h02,
        EC_PME  = 6'h04,
        EC_PPI  = 6'h07,
        EC_ALE  = 6'h09,
        EC_TLBR = 6'h3f
    } ecode_e;

    typedef struct packed {
        logic [2:0] vseg;
        logic [2:0] pseg;
        mat_t       mat;
        logic       plv3;
        logic       plv0;
    } dmw_t;

    typedef struct packed {
        logic       da;
        logic       pg;
        plv_t       plv;
        mat_t       datm;
        dmw_t       dmw0;
        dmw_t       dmw1;
        logic [9:0] asid;
    } csr_t;

    // One entry maps a single 4 KiB page
    typedef struct packed {
        logic        e;
        logic        g;
        logic [9:0]  asid;
        logic [19:0] vppn;
        logic [19:0] ppn;
        plv_t        plv;
        mat_t        mat;
        logic        d;
        logic        v;
    } tlb_entry_t;

    typedef struct packed {
        logic   valid;
        ecode_e ecode;
        u32_t   badv;
    } excp_pass_t;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

    import cpu_pkg::*;

    typedef enum logic [1:0] {
        DC_NOP = 2'd0,
        DC_R   = 2'd1,
        DC_W   = 2'd2
    } dcache_op_e;

    typedef struct packed {
        u32_t        pc;
        u32_t        pc_plus4;
        u32_t        ex_out;
        logic        is_mem;
        logic        is_store;
        logic        is_signed;
        byte_type_e  byte_type;
        logic        is_wr_rd;
        logic        is_wr_rd_pc_plus4;
        logic [4:0]  rd;
        logic        is_wr_csr;
        logic [13:0] csr_addr;
        logic        is_flush;
    } execute_memory1_pass_t;

    // byte_en carries the low address bits for the load aligner downstream
    typedef struct packed {
        u32_t        pc;
        u32_t        ex_out;
        logic        is_mem;
        logic        is_store;
        logic        is_signed;
        byte_type_e  byte_type;
        logic [1:0]  byte_en;
        logic        is_wr_rd;
        logic        is_wr_rd_pc_plus4;
        logic [4:0]  rd;
        logic        is_wr_csr;
        logic [13:0] csr_addr;
        logic        is_flush;
        u32_t        pa;
        mat_t        mat;
    } memory1_memory2_pass_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] idx;
        u32_t       data;
    } forward_req_t;

    typedef struct packed {
        logic [11:0] idx;
        dcache_op_e  op;
        u32_t        pa;
        logic        is_cached;
        byte_type_e  byte_type;
    } dcache_req_t;

endpackage

// File: logic/addr_trans.sv
`timescale 1ns/1ns

module addr_trans import cpu_pkg::*; (
    input  csr_t       csr,
    input  tlb_entry_t tlb_entries [TLB_ENTRY_NUM],
    input  logic       req,
    input  u32_t       va,
    input  lookup_e    lookup_type,
    input  byte_type_e byte_type,
    output u32_t       pa,
    output mat_t       mat,
    output excp_pass_t excp
);

    logic       misaligned;
    logic       dmw0_hit;
    logic       dmw1_hit;
    logic       tlb_hit;
    tlb_entry_t tlb_sel;
    ecode_e     ecode;

    // A window only opens for the privilege levels it enables
    function automatic logic window_hit(dmw_t win, plv_t plv, logic [2:0] vseg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && win.plv0) || (plv == 2'd3 && win.plv3);
        return plv_ok && (win.vseg == vseg);
    endfunction

    assign misaligned = (byte_type == BT_HALF && va[0])
                     || (byte_type == BT_WORD && va[1:0] != 2'b00);

    assign dmw0_hit = window_hit(csr.dmw0, csr.plv, va[31:29]);
    assign dmw1_hit = window_hit(csr.dmw1, csr.plv, va[31:29]);

    // Lowest matching entry wins, so scan from the top and let later hits overwrite
    always_comb begin
        tlb_hit = 1'b0;
        tlb_sel = tlb_entries[0];
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (tlb_entries[i].e && tlb_entries[i].vppn == va[31:12]
                    && (tlb_entries[i].g || tlb_entries[i].asid == csr.asid)) begin
                tlb_hit = 1'b1;
                tlb_sel = tlb_entries[i];
            end
        end
    end

    always_comb begin
        pa  = va;
        mat = csr.datm;
        if (!csr.da) begin
            if (dmw0_hit) begin
                pa  = {csr.dmw0.pseg, va[28:0]};
                mat = csr.dmw0.mat;
            end else if (dmw1_hit) begin
                pa  = {csr.dmw1.pseg, va[28:0]};
                mat = csr.dmw1.mat;
            end else begin
                pa  = {tlb_sel.ppn, va[11:0]};
                mat = tlb_sel.mat;
            end
        end
    end

    // Alignment is checked ahead of every translation fault
    always_comb begin
        ecode = EC_NONE;
        if (misaligned) begin
            ecode = EC_ALE;
        end else if (!csr.da && !dmw0_hit && !dmw1_hit) begin
            if (!tlb_hit) begin
                ecode = EC_TLBR;
            end else if (!tlb_sel.v) begin
                if (lookup_type == LOOKUP_STORE) begin
                    ecode = EC_PIS;
                end else begin
                    ecode = EC_PIL;
                end
            end else if (csr.plv > tlb_sel.plv) begin
                ecode = EC_PPI;
            end else if (lookup_type == LOOKUP_STORE && !tlb_sel.d) begin
                ecode = EC_PME;
            end
        end
    end

    assign excp.valid = req && (ecode != EC_NONE);
    assign excp.ecode = ecode;
    assign excp.badv  = va;

endmodule

// File: logic/mem1_stage.sv
`timescale 1ns/1ns

module mem1_stage import cpu_pkg::*, pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  csr_t                  csr,
    input  tlb_entry_t            tlb_entries [TLB_ENTRY_NUM],
    input  logic                  is_stall,
    input  logic                  is_flush,
    input  execute_memory1_pass_t pass_in,
    input  excp_pass_t            excp_in,
    output forward_req_t          fwd_req,
    output dcache_req_t           dcache_req,
    output memory1_memory2_pass_t pass_out,
    output excp_pass_t            excp_out
);

    execute_memory1_pass_t pass_r;
    excp_pass_t            excp_r;
    logic                  kill;
    lookup_e               lookup_type;
    u32_t                  trans_pa;
    mat_t                  trans_mat;
    excp_pass_t            trans_excp;

    // The stage comes out of reset holding a flushed bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid    <= 1'b0;
        end else if (!is_stall) begin
            pass_r <= pass_in;
            excp_r <= excp_in;
        end
    end

    assign kill        = is_flush | pass_r.is_flush;
    assign lookup_type = pass_r.is_store ? LOOKUP_STORE : LOOKUP_LOAD;

    addr_trans u_addr_trans (
        .csr         (csr),
        .tlb_entries (tlb_entries),
        .req         (pass_r.is_mem),
        .va          (pass_r.ex_out),
        .lookup_type (lookup_type),
        .byte_type   (pass_r.byte_type),
        .pa          (trans_pa),
        .mat         (trans_mat),
        .excp        (trans_excp)
    );

    // A killed instruction must not raise a fault of its own
    always_comb begin
        excp_out       = trans_excp;
        excp_out.valid = trans_excp.valid & ~kill;
        if (excp_r.valid) begin
            excp_out = excp_r;
        end
    end

    // Load-use hazards are resolved upstream by the stall level
    assign fwd_req.valid = pass_r.is_wr_rd & ~kill;
    assign fwd_req.idx   = pass_r.rd;
    assign fwd_req.data  = pass_r.is_wr_rd_pc_plus4 ? pass_r.pc_plus4 : pass_r.ex_out;

    always_comb begin
        dcache_req.op = DC_NOP;
        if (!kill && pass_r.is_mem && !excp_out.valid) begin
            if (pass_r.is_store) begin
                dcache_req.op = DC_W;
            end else begin
                dcache_req.op = DC_R;
            end
        end
    end

    assign dcache_req.idx       = pass_r.ex_out[11:0];
    assign dcache_req.pa        = trans_pa;
    assign dcache_req.is_cached = trans_mat[0];
    assign dcache_req.byte_type = pass_r.byte_type;

    assign pass_out.pc                = pass_r.pc;
    assign pass_out.ex_out            = pass_r.ex_out;
    assign pass_out.is_mem            = pass_r.is_mem;
    assign pass_out.is_store          = pass_r.is_store;
    assign pass_out.is_signed         = pass_r.is_signed;
    assign pass_out.byte_type         = pass_r.byte_type;
    assign pass_out.byte_en           = pass_r.ex_out[1:0];
    assign pass_out.is_wr_rd          = pass_r.is_wr_rd;
    assign pass_out.is_wr_rd_pc_plus4 = pass_r.is_wr_rd_pc_plus4;
    assign pass_out.rd                = pass_r.rd;
    assign pass_out.is_wr_csr         = pass_r.is_wr_csr;
    assign pass_out.csr_addr          = pass_r.csr_addr;
    assign pass_out.is_flush          = kill;
    assign pass_out.pa                = trans_pa;
    assign pass_out.mat               = trans_mat;

endmodule

// File: logic/mem1_unit.sv
`timescale 1ns/1ns

module mem1_unit import cpu_pkg::*, pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  csr_t                  csr,
    input  tlb_entry_t            tlb_entries [TLB_ENTRY_NUM],
    input  logic                  is_stall,
    input  logic                  is_flush,
    input  execute_memory1_pass_t pass_in,
    input  excp_pass_t            excp_in,
    output forward_req_t          fwd_req,
    output dcache_req_t           dcache_req,
    output memory1_memory2_pass_t pass_out,
    output excp_pass_t            excp_out
);

    mem1_stage u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr         (csr),
        .tlb_entries (tlb_entries),
        .is_stall    (is_stall),
        .is_flush    (is_flush),
        .pass_in     (pass_in),
        .excp_in     (excp_in),
        .fwd_req     (fwd_req),
        .dcache_req  (dcache_req),
        .pass_out    (pass_out),
        .excp_out    (excp_out)
    );

endmodule

// File: verif/mem1_clock.sv
`timescale 1ns/1ns

module mem1_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

// File: verif/mem1_assert.sv
`timescale 1ns/1ns

module mem1_assert import cpu_pkg::*, pipe_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  is_stall,
    input logic                  kill,
    input forward_req_t          fwd_req,
    input dcache_req_t           dcache_req,
    input memory1_memory2_pass_t pass_out,
    input excp_pass_t            excp_out
);

    int fail_count = 0;

    no_req_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
        (excp_out.valid || kill) |-> dcache_req.op == DC_NOP)
    else begin
        $error("cache request shown for a killed or faulting instruction");
        fail_count++;
    end

    // A held stall freezes the register, so every output repeats
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        is_stall |=> $stable(fwd_req) && $stable(dcache_req)
                     && $stable(pass_out) && $stable(excp_out))
    else begin
        $error("outputs changed while the stage was stalled");
        fail_count++;
    end

    no_fwd_after_reset: assert property (@(posedge clk) !rst_n |=> !fwd_req.valid)
    else begin
        $error("forwarding request valid in the cycle after reset");
        fail_count++;
    end

endmodule

bind mem1_stage mem1_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .is_stall   (is_stall),
    .kill       (kill),
    .fwd_req    (fwd_req),
    .dcache_req (dcache_req),
    .pass_out   (pass_out),
    .excp_out   (excp_out)
);

// File: verif/mem1_tb.sv
`timescale 1ns/1ns

module mem1_tb
    import cpu_pkg::*, pipe_pkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_TESTS      = 30;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * 4 + 20;

    logic                  clk;
    logic                  rst_n;
    csr_t                  csr;
    tlb_entry_t            tlb_entries [TLB_ENTRY_NUM];
    logic                  is_stall;
    logic                  is_flush;
    execute_memory1_pass_t pass_in;
    excp_pass_t            excp_in;
    forward_req_t          fwd_req;
    dcache_req_t           dcache_req;
    memory1_memory2_pass_t pass_out;
    excp_pass_t            excp_out;
    int unsigned           lcg_state = 32'd3;
    int                    cycle_count = 0;

    mem1_clock u_clock (.clk(clk), .rst_n(rst_n));

    mem1_unit u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr         (csr),
        .tlb_entries (tlb_entries),
        .is_stall    (is_stall),
        .is_flush    (is_flush),
        .pass_in     (pass_in),
        .excp_in     (excp_in),
        .fwd_req     (fwd_req),
        .dcache_req  (dcache_req),
        .pass_out    (pass_out),
        .excp_out    (excp_out)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic tlb_entry_t make_entry(logic g, logic [9:0] asid, logic [19:0] vppn,
                                              logic [19:0] ppn, plv_t plv, mat_t mat,
                                              logic d, logic v);
        tlb_entry_t ent;
        ent.e    = 1'b1;
        ent.g    = g;
        ent.asid = asid;
        ent.vppn = vppn;
        ent.ppn  = ppn;
        ent.plv  = plv;
        ent.mat  = mat;
        ent.d    = d;
        ent.v    = v;
        return ent;
    endfunction

    task automatic check_op(string name, dcache_op_e exp, dcache_op_e act);
        if (act !== exp) begin
            $display("error: %s op expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, u32_t exp, u32_t act);
        if (act !== exp) begin
            $display("error: %s pa expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Index, cacheability and size of a request that reaches the cache
    task automatic check_req(string name, dcache_req_t exp, dcache_req_t act);
        if (act.idx !== exp.idx || act.is_cached !== exp.is_cached
                || act.byte_type !== exp.byte_type) begin
            $display("error: %s request expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Only the valid bit matters when no exception is expected
    task automatic check_excp(string name, excp_pass_t exp, excp_pass_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            $display("error: %s excp expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fwd(string name, forward_req_t exp, forward_req_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            $display("error: %s fwd expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // The patterns give pa and mat only for accesses that reach the cache
    task automatic check_pass(string name, memory1_memory2_pass_t exp,
                              memory1_memory2_pass_t act, logic with_pa);
        memory1_memory2_pass_t e;
        memory1_memory2_pass_t a;
        e = exp;
        a = act;
        if (!with_pa) begin
            e.pa  = '0;
            e.mat = '0;
            a.pa  = '0;
            a.mat = '0;
        end
        if (a !== e) begin
            $display("error: %s pass_out expected %h actual %h", name, e, a);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin : main
        string                 line;
        string                 tname;
        int                    fd;
        int                    n;
        int                    stalls;
        int                    tests_run;
        logic [5:0]            crmd;
        logic [5:0]            xec;
        logic [5:0]            eec;
        logic [9:0]            dmw0_v;
        logic [9:0]            dmw1_v;
        logic [9:0]            asid_v;
        u32_t                  pc;
        u32_t                  va;
        u32_t                  epa;
        u32_t                  efd;
        logic [4:0]            rd;
        logic [1:0]            bt;
        logic [1:0]            eop;
        logic                  mem;
        logic                  st;
        logic                  wr;
        logic                  pc4;
        logic                  rfl;
        logic                  xv;
        logic                  lfl;
        logic                  stl;
        logic                  ecch;
        logic                  efv;
        excp_pass_t            exp_excp;
        forward_req_t          exp_fwd;
        dcache_req_t           exp_req;
        memory1_memory2_pass_t exp_pass;

        is_stall  = 1'b0;
        is_flush  = 1'b0;
        csr       = '0;
        pass_in   = '0;
        excp_in   = '0;
        tests_run = 0;
        tlb_entries[0] = make_entry(1'b1, 10'h000, 20'h00010, 20'h00480, 2'd3, 2'd1, 1'b1, 1'b1);
        tlb_entries[1] = make_entry(1'b0, 10'h005, 20'h00020, 20'h00500, 2'd0, 2'd0, 1'b1, 1'b1);
        tlb_entries[2] = make_entry(1'b1, 10'h000, 20'h00030, 20'h00600, 2'd3, 2'd1, 1'b0, 1'b1);
        tlb_entries[3] = make_entry(1'b1, 10'h000, 20'h00040, 20'h00700, 2'd3, 2'd1, 1'b1, 1'b0);

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_op("reset", DC_NOP, dcache_req.op);
        check_fwd("reset", '0, fwd_req);
        check_excp("reset", '0, excp_out);

        fd = $fopen("verif/mem1_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n != 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tname, crmd, dmw0_v, dmw1_v, asid_v, pc, va, mem, st, bt, wr, pc4, rd,
                    rfl, xv, xec, lfl, stl, eop, epa, ecch, eec, efv, efd);
                if (n != 24) begin
                    $display("malformed line in the pattern file: %s", line);
                    abort_run();
                end
                @(posedge clk);
                #10;
                csr                       = {crmd, dmw0_v, dmw1_v, asid_v};
                pass_in                   = '0;
                pass_in.pc                = pc;
                pass_in.pc_plus4          = pc + 32'd4;
                pass_in.ex_out            = va;
                pass_in.is_mem            = mem;
                pass_in.is_store          = st;
                pass_in.byte_type         = byte_type_e'(bt);
                pass_in.is_wr_rd          = wr;
                pass_in.is_wr_rd_pc_plus4 = pc4;
                pass_in.rd                = rd;
                pass_in.is_flush          = rfl;
                excp_in.valid             = xv;
                excp_in.ecode             = ecode_e'(xec);
                excp_in.badv              = pc;
                is_flush                  = lfl;
                stalls                    = stl ? int'(lcg_next() % 4) : 0;
                is_stall                  = (stalls != 0);
                if (stalls != 0) begin
                    repeat (stalls) @(posedge clk);
                    #10;
                    is_stall = 1'b0;
                end
                @(posedge clk);
                @(negedge clk);
                exp_excp.valid = (eec != 6'h00);
                exp_excp.ecode = ecode_e'(eec);
                exp_excp.badv  = xv ? pc : va;
                exp_fwd        = {efv, rd, efd};

                exp_req.idx       = va[11:0];
                exp_req.op        = dcache_op_e'(eop);
                exp_req.pa        = epa;
                exp_req.is_cached = ecch;
                exp_req.byte_type = byte_type_e'(bt);

                exp_pass                   = '0;
                exp_pass.pc                = pc;
                exp_pass.ex_out            = va;
                exp_pass.is_mem            = mem;
                exp_pass.is_store          = st;
                exp_pass.byte_type         = byte_type_e'(bt);
                exp_pass.byte_en           = va[1:0];
                exp_pass.is_wr_rd          = wr;
                exp_pass.is_wr_rd_pc_plus4 = pc4;
                exp_pass.rd                = rd;
                exp_pass.is_flush          = rfl | lfl;
                exp_pass.pa                = epa;
                exp_pass.mat               = {1'b0, ecch};

                check_op(tname, dcache_op_e'(eop), dcache_req.op);
                if (eop != 2'd0) begin
                    check_addr(tname, epa, dcache_req.pa);
                    check_req(tname, exp_req, dcache_req);
                end
                check_excp(tname, exp_excp, excp_out);
                check_fwd(tname, exp_fwd, fwd_req);
                check_pass(tname, exp_pass, pass_out, eop != 2'd0);
                tests_run++;
            end
        end
        $fclose(fd);

        if (tests_run != NUM_TESTS) begin
            $display("only %0d of %0d tests were read", tests_run, NUM_TESTS);
            abort_run();
        end else if (u_dut.u_stage.u_assert.fail_count != 0) begin
            $display("%0d assertion failures", u_dut.u_stage.u_assert.fail_count);
            abort_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: mem1_unit.f
logic/cpu_pkg.sv
logic/pipe_pkg.sv
logic/addr_trans.sv
logic/mem1_stage.sv
logic/mem1_unit.sv
verif/mem1_clock.sv
verif/mem1_assert.sv
verif/mem1_tb.sv

// File: verif/mem1_patterns.txt
# name crmd dmw0 dmw1 asid pc ex_out mem st bt wr pc4 rd rflush xv xecode lflush stall
# then expected op pa cached ecode fwd_valid fwd_data, every number in hex
da_load_word 21 205 281 000 1c000000 00012344 1 0 2 1 0 04 0 0 00 0 0 1 00012344 1 00 1 00012344
da_store_unc 20 205 281 000 1c000010 0abc0010 1 1 2 0 0 00 0 0 00 0 0 2 0abc0010 0 00 0 00000000
dmw0_load 10 205 281 000 1c000020 80001230 1 0 2 1 0 05 0 0 00 0 0 1 00001230 1 00 1 80001230
dmw1_st_byte 10 205 281 000 1c000030 a0004567 1 1 0 0 0 00 0 0 00 0 0 2 00004567 0 00 0 00000000
dmw0_priority 10 295 281 000 1c000040 a0000010 1 0 2 1 0 06 0 0 00 0 0 1 20000010 1 00 1 a0000010
dmw_plv3_miss 1c 205 281 000 1c000050 80001000 1 0 2 0 0 00 0 0 00 0 0 0 00000000 0 3f 0 00000000
tlb_global 10 205 281 000 1c000060 00010ab8 1 0 2 1 0 07 0 0 00 0 0 1 00480ab8 1 00 1 00010ab8
tlb_asid_hit 10 205 281 005 1c000070 00020004 1 0 2 1 0 08 0 0 00 0 0 1 00500004 0 00 1 00020004
tlb_asid_miss 10 205 281 006 1c000080 00020004 1 0 2 1 0 08 0 0 00 0 0 0 00000000 0 3f 1 00020004
tlb_miss 10 205 281 000 1c000090 00090000 1 0 2 0 0 00 0 0 00 0 0 0 00000000 0 3f 0 00000000
tlb_inv_load 10 205 281 000 1c0000a0 00040010 1 0 2 0 0 00 0 0 00 0 0 0 00000000 0 01 0 00000000
tlb_inv_store 10 205 281 000 1c0000b0 00040010 1 1 2 0 0 00 0 0 00 0 0 0 00000000 0 02 0 00000000
tlb_plv_fault 1c 205 281 005 1c0000c0 00020008 1 0 2 0 0 00 0 0 00 0 0 0 00000000 0 07 0 00000000
tlb_clean_st 10 205 281 000 1c0000d0 00030020 1 1 2 0 0 00 0 0 00 0 0 0 00000000 0 04 0 00000000
tlb_clean_ld 10 205 281 000 1c0000e0 00030020 1 0 2 1 0 09 0 0 00 0 0 1 00600020 1 00 1 00030020
tlb_user_st 1c 205 281 000 1c0000f0 00010100 1 1 1 0 0 00 0 0 00 0 0 2 00480100 1 00 0 00000000
ale_half 10 205 281 000 1c000100 00010101 1 0 1 0 0 00 0 0 00 0 0 0 00000000 0 09 0 00000000
ale_over_tlbr 10 205 281 000 1c000110 00090002 1 1 2 0 0 00 0 0 00 0 0 0 00000000 0 09 0 00000000
excp_in_pass 10 205 281 000 1c000120 00090000 1 0 2 0 0 00 0 1 07 0 0 0 00000000 0 07 0 00000000
excp_over_ale 10 205 281 000 1c000130 00010101 1 0 1 0 0 00 0 1 01 0 0 0 00000000 0 01 0 00000000
fwd_pc_plus4 10 205 281 000 1c000140 00000000 0 0 2 1 1 01 0 0 00 0 0 0 00000000 0 00 1 1c000144
fwd_ex_out 21 205 281 000 1c000150 12345678 0 0 2 1 0 0a 0 0 00 0 0 0 00000000 0 00 1 12345678
flush_level 21 205 281 000 1c000160 00000100 1 0 2 1 0 0b 0 0 00 1 0 0 00000000 0 00 0 00000000
flush_record 21 205 281 000 1c000170 00000100 1 0 2 1 0 0b 1 0 00 0 0 0 00000000 0 00 0 00000000
flush_fault 10 205 281 000 1c000180 00010101 1 0 1 1 0 0c 1 0 00 0 0 0 00000000 0 00 0 00000000
stall_dmw 10 205 281 000 1c000190 80002340 1 0 2 1 0 0d 0 0 00 0 1 1 00002340 1 00 1 80002340
stall_tlb_st 10 205 281 000 1c0001a0 00010200 1 1 2 0 0 00 0 0 00 0 1 2 00480200 1 00 0 00000000
stall_tlbr 10 205 281 000 1c0001b0 00090010 1 0 2 1 0 0e 0 0 00 0 1 0 00000000 0 3f 1 00090010
stall_fwd 10 205 281 000 1c0001c0 00000000 0 0 2 1 1 0f 0 0 00 0 1 0 00000000 0 00 1 1c0001c4
stall_da_byte 21 205 281 000 1c0001d0 0000abcd 1 0 0 1 0 10 0 0 00 0 1 1 0000abcd 1 00 1 0000abcd
